//--- dv/vex_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vex_tb;
    import vex_pkg::*;

    // write-backs and uops of all tests together
    localparam int NUM_UOPS = 182;

    logic        CLK;
    logic        reset;
    word_t       rdat1;
    word_t       rdat2;
    vcontrol_t   vctrls;
    vwb_t        vwb_ctrls;
    mask_fwd_t   mask_fwd;
    vexmem_t     vmem_in;
    logic        vex_stall;

    logic [31:0] seed;
    word_t       shadow [NUM_VREGS][NUM_LANES];
    int          errors;
    int          uops_sent;
    int          uops_checked;
    int          last_seen;
    logic        stall_prev;

    vex_datapath u_vex_datapath (
        .CLK       (CLK),
        .reset     (reset),
        .rdat1     (rdat1),
        .rdat2     (rdat2),
        .vctrls    (vctrls),
        .vwb_ctrls (vwb_ctrls),
        .mask_fwd  (mask_fwd),
        .vmem_in   (vmem_in),
        .vex_stall (vex_stall)
    );

    always #10 CLK = ~CLK;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        // high bits of an LCG are the better ones
        return {seed[23:0], seed[31:24]};
    endfunction

    // element u of a bank word at the given width, then extended
    function automatic word_t pick_elem(word_t w, sew_t eew, logic [1:0] u, logic sx);
        logic [15:0] h;
        logic [7:0]  b;
        h = 16'(w >> (16 * u[0]));
        b = 8'(w >> (8 * u));
        case (eew)
            SEW8:    return sx ? {{24{b[7]}}, b} : {24'b0, b};
            SEW16:   return sx ? {{16{h[15]}}, h} : {16'b0, h};
            default: return w;
        endcase
    endfunction

    function automatic word_t alu_ref(valu_op_t op, word_t a, word_t b);
        case (op)
            VALU_ADD: return a + b;
            VALU_SUB: return a - b;
            VALU_AND: return a & b;
            VALU_OR:  return a | b;
            VALU_XOR: return a ^ b;
            VALU_SLL: return a << b[4:0];
            VALU_SRL: return a >> b[4:0];
            VALU_SRA: return $signed(a) >>> b[4:0];
            VALU_MUL: return a * b;
            VALU_SEQ: return {31'b0, a == b};
            VALU_SNE: return {31'b0, a != b};
            VALU_SLT: return {31'b0, $signed(a) < $signed(b)};
            VALU_SLE: return {31'b0, $signed(a) <= $signed(b)};
            VALU_SGT: return {31'b0, $signed(a) > $signed(b)};
            default:  return '0;
        endcase
    endfunction

    function automatic vexmem_t ref_vexmem(vcontrol_t c, word_t r1, word_t r2, mask_fwd_t f);
        vexmem_t              e;
        word_t                src1;
        word_t                src2;
        word_t                op_a;
        word_t                op_b;
        word_t                imm;
        word_t                res [NUM_LANES];
        logic [NUM_LANES-1:0] lm;
        logic [15:0]          m;
        logic                 cmp;
        cmp = c.valuop inside {VALU_SEQ, VALU_SNE, VALU_SLT, VALU_SLE, VALU_SGT};
        imm = (c.vsignext || cmp) ? {{27{c.vimm[4]}}, c.vimm} : {27'b0, c.vimm};
        e = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            src1 = pick_elem(shadow[c.vs1_sel][k], c.veew_src1, c.vuop_num, c.vsignext);
            src2 = pick_elem(shadow[c.vs2_sel][k], c.veew_src2, c.vuop_num, c.vsignext);
            if (c.vxin1_use_imm) begin
                op_b = imm;
            end else if (c.vxin1_use_rs1) begin
                op_b = (c.vmemdren || c.vmemdwen) ? r1
                                                  : pick_elem(r1, c.veew_src1, 2'd0, c.vsignext);
            end else begin
                op_b = src1;
            end
            op_a = c.vxin2_use_rs2 ? r2 : src2;
            res[k] = alu_ref(c.valuop, op_a, op_b);
            e.vs1[k] = src1;
            lm[k] = (c.vmask_en ? shadow[0][0][4 * c.vuop_num + k] : 1'b1) & c.vlaneactive[k];
        end
        if (cmp) begin
            m = shadow[c.vd_sel][0][15:0];
            if (f.valid && c.vuop_num != 2'd0) begin
                m[4 * (c.vuop_num - 1) +: 4] = f.bits;
            end
            for (int k = 0; k < NUM_LANES; k++) begin
                if (lm[k]) begin
                    m[4 * c.vuop_num + k] = res[k][0];
                end
            end
            for (int k = 0; k < NUM_LANES; k++) begin
                e.vres[k] = {16'b0, m};
            end
            e.vlane_mask = 4'b0001;
            e.vmskset    = 1'b1;
        end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
                e.vres[k] = res[k];
            end
            e.vlane_mask = lm;
            e.vmskset    = 1'b0;
        end
        e.vuop_num = c.vuop_num;
        e.vd_sel   = c.vd_sel;
        e.veew     = c.veew_dest;
        e.vregwen  = c.vregwen;
        e.vmemdren = c.vmemdren;
        e.vmemdwen = c.vmemdwen;
        return e;
    endfunction

    function automatic vcontrol_t rand_ctrl();
        vcontrol_t   c;
        logic [31:0] r;
        c = '0;
        r = next_rand();
        c.vs1_sel     = r[4:0];
        c.vs2_sel     = r[9:5];
        c.vd_sel      = r[14:10];
        c.vuop_num    = r[16:15];
        c.vsignext    = r[17];
        c.vimm        = r[22:18];
        c.veew_src1   = sew_t'(next_rand() % 3);
        c.veew_src2   = sew_t'(next_rand() % 3);
        c.veew_dest   = c.veew_src2;
        c.valuop      = valu_op_t'(next_rand() % 8);
        c.vlaneactive = 4'hF;
        c.vregwen     = 1'b1;
        return c;
    endfunction

    // mirrors the banks, same edge and same inputs
    always @(posedge CLK) begin
        for (int r = 0; r < NUM_VREGS; r++) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                if (reset) begin
                    shadow[r][k] = '0;
                end else if (vwb_ctrls.vd == 5'(r)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (vwb_ctrls.vbyte_wen[k][b]) begin
                            shadow[r][k][8*b +: 8] = vwb_ctrls.vwdata[k][8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    task automatic write_back(input logic [4:0] vd, input logic [15:0] wen);
        vwb_t wb;
        wb.vd = vd;
        for (int k = 0; k < NUM_LANES; k++) begin
            wb.vwdata[k] = next_rand();
        end
        wb.vbyte_wen = wen;
        vwb_ctrls <= wb;
        vctrls    <= '0;
        @(posedge CLK);
    endtask

    // present a uop and hold it while the stage stalls
    task automatic send_uop(input vcontrol_t c, input word_t r1, input word_t r2,
                            input mask_fwd_t f);
        vctrls    <= c;
        rdat1     <= r1;
        rdat2     <= r2;
        mask_fwd  <= f;
        vwb_ctrls <= '0;
        uops_sent <= uops_sent + 1;
        @(negedge CLK);
        while (vex_stall) begin
            @(negedge CLK);
        end
        @(posedge CLK);
    endtask

    always @(negedge CLK) begin
        vexmem_t expd;
        if (!reset) begin
            assert (!(vex_stall && stall_prev)) else begin
                $display("ERROR: vex_stall stayed high for more than one cycle at %0t", $time);
                errors++;
            end
            if (uops_sent != last_seen) begin
                assert (vex_stall == (vctrls.valuop == VALU_MUL)) else begin
                    $display("ERROR: vex_stall was %0b in the first cycle of a %s uop at %0t",
                             vex_stall, vctrls.valuop.name(), $time);
                    errors++;
                end
                last_seen = uops_sent;
            end
            if (uops_checked != uops_sent && !vex_stall) begin
                expd = ref_vexmem(vctrls, rdat1, rdat2, mask_fwd);
                for (int k = 0; k < NUM_LANES; k++) begin
                    if (expd.vlane_mask[k]) begin
                        assert (vmem_in.vres[k] == expd.vres[k]) else begin
                            $display("MISMATCH %0t vres lane %0d got %h expected %h",
                                     $time, k, vmem_in.vres[k], expd.vres[k]);
                            errors++;
                        end
                    end
                end
                assert (vmem_in.vlane_mask == expd.vlane_mask) else begin
                    $display("MISMATCH %0t vlane_mask got %b expected %b",
                             $time, vmem_in.vlane_mask, expd.vlane_mask);
                    errors++;
                end
                assert (vmem_in.vs1 == expd.vs1) else begin
                    $display("MISMATCH %0t vs1 got %h expected %h", $time, vmem_in.vs1, expd.vs1);
                    errors++;
                end
                assert (vmem_in.vmskset == expd.vmskset) else begin
                    $display("MISMATCH %0t vmskset got %b expected %b",
                             $time, vmem_in.vmskset, expd.vmskset);
                    errors++;
                end
                // control passed on to the memory stage
                assert (vmem_in.vuop_num == expd.vuop_num && vmem_in.vd_sel == expd.vd_sel &&
                        vmem_in.veew == expd.veew && vmem_in.vregwen == expd.vregwen &&
                        vmem_in.vmemdren == expd.vmemdren &&
                        vmem_in.vmemdwen == expd.vmemdwen) else begin
                    $display("MISMATCH %0t control got uop %0d vd %0d eew %0d en %b%b%b",
                             $time, vmem_in.vuop_num, vmem_in.vd_sel, vmem_in.veew,
                             vmem_in.vregwen, vmem_in.vmemdren, vmem_in.vmemdwen);
                    $display("MISMATCH %0t control expected uop %0d vd %0d eew %0d en %b%b%b",
                             $time, expd.vuop_num, expd.vd_sel, expd.veew,
                             expd.vregwen, expd.vmemdren, expd.vmemdwen);
                    errors++;
                end
                uops_checked++;
            end
        end
        stall_prev = vex_stall;
    end

    initial begin
        repeat (NUM_UOPS * 3 + 100) @(posedge CLK);
        $display("ERROR: watchdog timeout, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        vcontrol_t   c;
        mask_fwd_t   f;
        logic [31:0] r;
        CLK          = 1'b0;
        reset        = 1'b1;
        rdat1        = '0;
        rdat2        = '0;
        vctrls       = '0;
        vwb_ctrls    = '0;
        mask_fwd     = '0;
        seed         = 32'h03e4b500;
        errors       = 0;
        uops_sent    = 0;
        uops_checked = 0;
        last_seen    = 0;
        stall_prev   = 1'b0;
        repeat (16) @(posedge CLK);
        reset <= 1'b0;

        // cleared banks
        repeat (8) begin
            c = rand_ctrl();
            c.valuop = VALU_ADD;
            send_uop(c, '0, '0, '0);
        end

        // vector-vector over all widths, offsets and sign modes
        repeat (64) begin
            r = next_rand();
            write_back(r[4:0], r[31:16]);
        end
        for (int s = 0; s < 3; s++) begin
            for (int u = 0; u < 4; u++) begin
                for (int sx = 0; sx < 2; sx++) begin
                    c = rand_ctrl();
                    c.veew_src1 = sew_t'(s);
                    c.veew_src2 = sew_t'(s);
                    c.vuop_num  = 2'(u);
                    c.vsignext  = sx[0];
                    send_uop(c, next_rand(), next_rand(), '0);
                end
            end
        end

        // immediate and scalar operands
        repeat (24) begin
            c = rand_ctrl();
            r = next_rand();
            c.valuop = valu_op_t'(r % 14);
            if (c.valuop == VALU_MUL) begin
                c.valuop = VALU_SLT;
            end
            c.vxin1_use_imm = r[20];
            c.vxin1_use_rs1 = !r[20];
            c.vxin2_use_rs2 = r[21];
            c.vmemdwen      = r[22] & r[23];
            send_uop(c, next_rand(), next_rand(), '0);
        end

        // masked execution from a fresh v0
        repeat (4) begin
            write_back(5'd0, 16'hFFFF);
            repeat (8) begin
                c = rand_ctrl();
                r = next_rand();
                c.vmask_en    = 1'b1;
                c.vlaneactive = r[3:0];
                send_uop(c, next_rand(), next_rand(), '0);
            end
        end

        // compares into a mask register, with and without forwarding
        for (int u = 0; u < 4; u++) begin
            for (int op = 0; op < 5; op++) begin
                c = rand_ctrl();
                r = next_rand();
                c.valuop        = valu_op_t'(9 + op);
                c.vuop_num      = 2'(u);
                c.vmask_en      = r[0];
                c.vlaneactive   = r[7:4];
                c.vxin1_use_imm = r[8];
                f.valid         = r[12];
                f.bits          = r[19:16];
                send_uop(c, next_rand(), next_rand(), f);
            end
        end

        // back-to-back multiplies, then a multiply followed by an add
        repeat (4) begin
            c = rand_ctrl();
            c.valuop = VALU_MUL;
            send_uop(c, next_rand(), next_rand(), '0);
        end
        c = rand_ctrl();
        c.valuop = VALU_MUL;
        send_uop(c, next_rand(), next_rand(), '0);
        c.valuop = VALU_ADD;
        send_uop(c, next_rand(), next_rand(), '0);

        vctrls <= '0;
        repeat (2) @(posedge CLK);
        assert (uops_checked == uops_sent) else begin
            $display("ERROR: %0d uops were sent but never checked", uops_sent - uops_checked);
            errors++;
        end
        $display("uops checked: %0d, errors: %0d", uops_checked, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/lane_alu.sv
`timescale 1ns/10ps
`default_nettype none

module lane_alu (
    input  logic             CLK,
    input  logic             reset,
    input  vex_pkg::word_t   vop_a,
    input  vex_pkg::word_t   vop_b,
    input  vex_pkg::valu_op_t valuop,
    output vex_pkg::word_t   vres,
    output logic             vfu_stall
);
    import vex_pkg::*;

    logic       mul_busy;
    word_t      prod_q;
    word_t      product;
    word_t      alu_res;
    logic       cmp_true;
    logic [4:0] shamt;

    assign shamt   = vop_b[4:0];
    assign product = vop_a * vop_b;

    // first cycle of a MUL stalls, second cycle presents the product
    assign vfu_stall = (valuop == VALU_MUL) && !mul_busy;

    always_ff @(posedge CLK) begin
        if (reset) begin
            mul_busy <= 1'b0;
        end else begin
            mul_busy <= vfu_stall;
        end
    end

    always_ff @(posedge CLK) begin
        if (vfu_stall) begin
            prod_q <= product;
        end
    end

    always_comb begin
        alu_res  = '0;
        cmp_true = 1'b0;
        case (valuop)
            VALU_ADD: alu_res = vop_a + vop_b;
            VALU_SUB: alu_res = vop_a - vop_b;
            VALU_AND: alu_res = vop_a & vop_b;
            VALU_OR:  alu_res = vop_a | vop_b;
            VALU_XOR: alu_res = vop_a ^ vop_b;
            VALU_SLL: alu_res = vop_a << shamt;
            VALU_SRL: alu_res = vop_a >> shamt;
            VALU_SRA: alu_res = $signed(vop_a) >>> shamt;
            VALU_MUL: alu_res = prod_q;
            // compares are signed
            VALU_SEQ: cmp_true = (vop_a == vop_b);
            VALU_SNE: cmp_true = (vop_a != vop_b);
            VALU_SLT: cmp_true = ($signed(vop_a) <  $signed(vop_b));
            VALU_SLE: cmp_true = ($signed(vop_a) <= $signed(vop_b));
            VALU_SGT: cmp_true = ($signed(vop_a) >  $signed(vop_b));
            default: begin
                alu_res  = '0;
                cmp_true = 1'b0;
            end
        endcase
    end

    assign vres = is_mask_set_op(valuop) ? {31'b0, cmp_true} : alu_res;

    // the held op decides what the second cycle shows
    a_op_known_busy: assert property (@(posedge CLK) disable iff (reset)
        mul_busy |-> !$isunknown(valuop));

endmodule

`default_nettype wire

//--- hw/mask_set_layer.sv
`timescale 1ns/10ps
`default_nettype none

module mask_set_layer (
    input  logic [3:0]        cmp_bits,
    input  vex_pkg::word_t    vd_word,
    input  vex_pkg::mask_fwd_t fwd,
    input  logic [3:0]        lane_mask,
    input  logic [1:0]        uop_num,
    output logic [15:0]       vmskset_res
);
    import vex_pkg::*;

    logic [1:0] prev_uop;

    assign prev_uop = uop_num - 2'd1;

    always_comb begin
        // old mask register contents
        vmskset_res = vd_word[15:0];

        // previous uop's bits may still be in flight
        if (fwd.valid && (uop_num != 2'd0)) begin
            vmskset_res[{prev_uop, 2'b00} +: 4] = fwd.bits;
        end

        // this uop's compare results, masked lanes keep old bits
        for (int k = 0; k < NUM_LANES; k++) begin
            if (lane_mask[k]) begin
                vmskset_res[{uop_num, 2'(k)}] = cmp_bits[k];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mask_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mask_unit (
    input  vex_pkg::word_t v0,
    input  logic           mask_enable,
    input  logic [1:0]     uop_num,
    input  logic [3:0]     lane_active,
    output logic [3:0]     lane_mask,
    output logic [3:0]     mask_bits
);
    import vex_pkg::*;

    // element index is uop_num*4 + lane
    always_comb begin
        logic [4:0] elem_idx;
        mask_bits = '1;
        for (int k = 0; k < NUM_LANES; k++) begin
            elem_idx = {1'b0, uop_num, 2'(k)};
            if (mask_enable) begin
                mask_bits[k] = v0[elem_idx];
            end
        end
    end

    // inactive lanes never write
    assign lane_mask = mask_bits & lane_active;

endmodule

`default_nettype wire

//--- hw/read_xbar.sv
`timescale 1ns/10ps
`default_nettype none

module read_xbar (
    input  vex_pkg::lane_words_t bank_dat,
    input  vex_pkg::sew_t        veew,
    input  logic [1:0]           bank_offset,
    input  logic                 sign_ext,
    output vex_pkg::lane_words_t out_dat
);
    import vex_pkg::*;

    always_comb begin
        logic [15:0] half;
        logic [7:0]  byte_val;
        out_dat = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            half     = bank_offset[0] ? bank_dat[k][31:16] : bank_dat[k][15:0];
            byte_val = bank_dat[k][8*bank_offset +: 8];
            case (veew)
                SEW8: begin
                    if (sign_ext) begin
                        out_dat[k] = {{24{byte_val[7]}}, byte_val};
                    end else begin
                        out_dat[k] = {24'b0, byte_val};
                    end
                end
                SEW16: begin
                    // only the low offset bit picks the halfword
                    if (sign_ext) begin
                        out_dat[k] = {{16{half[15]}}, half};
                    end else begin
                        out_dat[k] = {16'b0, half};
                    end
                end
                default: begin
                    out_dat[k] = bank_dat[k];
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/vector_bank.sv
`timescale 1ns/10ps
`default_nettype none

module vector_bank (
    input  logic          CLK,
    input  logic          reset,
    input  logic [4:0]    vs1,
    input  logic [4:0]    vs2,
    input  logic [4:0]    vw,
    input  vex_pkg::word_t vwdata,
    input  logic [3:0]    byte_wen,
    input  logic [4:0]    vd_sel,
    output vex_pkg::word_t vdat1,
    output vex_pkg::word_t vdat2,
    output vex_pkg::word_t v0,
    output vex_pkg::word_t vdat3
);
    import vex_pkg::*;

    word_t regs [NUM_VREGS];

    // v0 is writable, it holds the mask
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (byte_wen[b]) begin
                    regs[vw][8*b +: 8] <= vwdata[8*b +: 8];
                end
            end
        end
    end

    // zero-latency reads, no write bypass
    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];
    assign v0    = regs[0];
    assign vdat3 = regs[vd_sel];

    a_byte_wen_known: assert property (@(posedge CLK) disable iff (reset)
        !$isunknown(byte_wen));

endmodule

`default_nettype wire

//--- hw/vex_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module vex_datapath (
    input  logic               CLK,
    input  logic               reset,
    input  vex_pkg::word_t     rdat1,
    input  vex_pkg::word_t     rdat2,
    input  vex_pkg::vcontrol_t vctrls,
    input  vex_pkg::vwb_t      vwb_ctrls,
    input  vex_pkg::mask_fwd_t mask_fwd,
    output vex_pkg::vexmem_t   vmem_in,
    output logic               vex_stall
);
    import vex_pkg::*;

    lane_words_t          bankdat_src1;
    lane_words_t          bankdat_src2;
    lane_words_t          bank_v0;
    lane_words_t          bank_vd;
    lane_words_t          xbardat_src1;
    lane_words_t          xbardat_src2;
    lane_words_t          vop_a;
    lane_words_t          vop_b;
    lane_words_t          alu_res;
    logic [NUM_LANES-1:0] lane_stall;
    logic [NUM_LANES-1:0] msku_lane_mask;
    logic [NUM_LANES-1:0] cmp_bits;
    logic [15:0]          vmskset_res;
    logic                 is_cmp;
    word_t                ext_imm;
    word_t                rs1_ext;

    assign is_cmp = is_mask_set_op(vctrls.valuop);

    // compares always take a signed immediate
    assign ext_imm = (vctrls.vsignext || is_cmp) ? {{27{vctrls.vimm[4]}}, vctrls.vimm}
                                                 : {27'b0, vctrls.vimm};

    // scalar narrowed to source width, memory uops use it whole
    always_comb begin
        rs1_ext = rdat1;
        if (!(vctrls.vmemdren || vctrls.vmemdwen)) begin
            case (vctrls.veew_src1)
                SEW8:  rs1_ext = vctrls.vsignext ? {{24{rdat1[7]}}, rdat1[7:0]}
                                                 : {24'b0, rdat1[7:0]};
                SEW16: rs1_ext = vctrls.vsignext ? {{16{rdat1[15]}}, rdat1[15:0]}
                                                 : {16'b0, rdat1[15:0]};
                default: rs1_ext = rdat1;
            endcase
        end
    end

    always_comb begin
        vop_b = xbardat_src1;
        vop_a = xbardat_src2;
        if (vctrls.vxin1_use_imm) begin
            vop_b = {NUM_LANES{ext_imm}};
        end else if (vctrls.vxin1_use_rs1) begin
            vop_b = {NUM_LANES{rs1_ext}};
        end
        if (vctrls.vxin2_use_rs2) begin
            vop_a = {NUM_LANES{rdat2}};
        end
    end

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        vector_bank u_vector_bank (
            .CLK      (CLK),
            .reset    (reset),
            .vs1      (vctrls.vs1_sel),
            .vs2      (vctrls.vs2_sel),
            .vw       (vwb_ctrls.vd),
            .vwdata   (vwb_ctrls.vwdata[k]),
            .byte_wen (vwb_ctrls.vbyte_wen[k]),
            .vd_sel   (vctrls.vd_sel),
            .vdat1    (bankdat_src1[k]),
            .vdat2    (bankdat_src2[k]),
            .v0       (bank_v0[k]),
            .vdat3    (bank_vd[k])
        );

        lane_alu u_lane_alu (
            .CLK       (CLK),
            .reset     (reset),
            .vop_a     (vop_a[k]),
            .vop_b     (vop_b[k]),
            .valuop    (vctrls.valuop),
            .vres      (alu_res[k]),
            .vfu_stall (lane_stall[k])
        );

        assign cmp_bits[k] = alu_res[k][0];
    end

    assign vex_stall = |lane_stall;

    read_xbar u_xbar_src1 (
        .bank_dat    (bankdat_src1),
        .veew        (vctrls.veew_src1),
        .bank_offset (vctrls.vuop_num),
        .sign_ext    (vctrls.vsignext),
        .out_dat     (xbardat_src1)
    );

    read_xbar u_xbar_src2 (
        .bank_dat    (bankdat_src2),
        .veew        (vctrls.veew_src2),
        .bank_offset (vctrls.vuop_num),
        .sign_ext    (vctrls.vsignext),
        .out_dat     (xbardat_src2)
    );

    // mask register lives in bank 0
    mask_unit u_mask_unit (
        .v0          (bank_v0[0]),
        .mask_enable (vctrls.vmask_en),
        .uop_num     (vctrls.vuop_num),
        .lane_active (vctrls.vlaneactive),
        .lane_mask   (msku_lane_mask),
        .mask_bits   ()
    );

    mask_set_layer u_mask_set_layer (
        .cmp_bits    (cmp_bits),
        .vd_word     (bank_vd[0]),
        .fwd         (mask_fwd),
        .lane_mask   (msku_lane_mask),
        .uop_num     (vctrls.vuop_num),
        .vmskset_res (vmskset_res)
    );

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            vmem_in.vres[k] = is_cmp ? {16'b0, vmskset_res} : alu_res[k];
        end
        // store data
        vmem_in.vs1        = xbardat_src1;
        vmem_in.vlane_mask = is_cmp ? 4'b0001 : msku_lane_mask;
        vmem_in.vmskset    = is_cmp;
        vmem_in.vuop_num   = vctrls.vuop_num;
        vmem_in.vd_sel     = vctrls.vd_sel;
        vmem_in.veew       = vctrls.veew_dest;
        vmem_in.vregwen    = vctrls.vregwen;
        vmem_in.vmemdren   = vctrls.vmemdren;
        vmem_in.vmemdwen   = vctrls.vmemdwen;
    end

    // a multiply holds the stage for one cycle only
    a_stall_one_cycle: assert property (@(posedge CLK) disable iff (reset)
        vex_stall |=> !vex_stall);

endmodule

`default_nettype wire

//--- hw/vex_pkg.sv
`default_nettype none

package vex_pkg;

    localparam int NUM_LANES = 4;
    localparam int NUM_VREGS = 32;

    typedef logic [31:0] word_t;
    typedef word_t [NUM_LANES-1:0] lane_words_t;

    // element width, shared by sources and destination
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    typedef enum logic [3:0] {
        VALU_ADD = 4'd0,
        VALU_SUB = 4'd1,
        VALU_AND = 4'd2,
        VALU_OR  = 4'd3,
        VALU_XOR = 4'd4,
        VALU_SLL = 4'd5,
        VALU_SRL = 4'd6,
        VALU_SRA = 4'd7,
        VALU_MUL = 4'd8,
        VALU_SEQ = 4'd9,
        VALU_SNE = 4'd10,
        VALU_SLT = 4'd11,
        VALU_SLE = 4'd12,
        VALU_SGT = 4'd13
    } valu_op_t;

    // decoded uop as seen by execute
    typedef struct packed {
        valu_op_t           valuop;
        logic [4:0]         vs1_sel;
        logic [4:0]         vs2_sel;
        logic [4:0]         vd_sel;
        sew_t               veew_src1;
        sew_t               veew_src2;
        sew_t               veew_dest;
        logic [1:0]         vuop_num;
        logic               vsignext;
        logic [4:0]         vimm;
        logic               vxin1_use_imm;
        logic               vxin1_use_rs1;
        logic               vxin2_use_rs2;
        logic               vmask_en;
        logic [NUM_LANES-1:0] vlaneactive;
        logic               vregwen;
        logic               vmemdren;
        logic               vmemdwen;
    } vcontrol_t;

    // write-back request coming back from a later stage
    typedef struct packed {
        logic [4:0]                vd;
        lane_words_t               vwdata;
        logic [NUM_LANES-1:0][3:0] vbyte_wen;
    } vwb_t;

    // mask bits of a compare uop not yet written back
    typedef struct packed {
        logic                 valid;
        logic [NUM_LANES-1:0] bits;
    } mask_fwd_t;

    typedef struct packed {
        lane_words_t          vres;
        lane_words_t          vs1;
        logic [NUM_LANES-1:0] vlane_mask;
        logic [1:0]           vuop_num;
        logic [4:0]           vd_sel;
        sew_t                 veew;
        logic                 vregwen;
        logic                 vmemdren;
        logic                 vmemdwen;
        logic                 vmskset;
    } vexmem_t;

    // compares write a mask register instead of element data
    function automatic logic is_mask_set_op(valu_op_t op);
        return (op == VALU_SEQ) || (op == VALU_SNE) || (op == VALU_SLT) ||
               (op == VALU_SLE) || (op == VALU_SGT);
    endfunction

endpackage

`default_nettype wire

//--- vex.f
hw/vex_pkg.sv
hw/vector_bank.sv
hw/read_xbar.sv
hw/lane_alu.sv
hw/mask_unit.sv
hw/mask_set_layer.sv
hw/vex_datapath.sv
dv/vex_tb.sv
